// ==== logic/uart_pkg.sv ====
package uart_pkg;

  // Register word addresses on the 3-bit bus
  typedef enum logic [2:0] {
    reg_txdata = 3'd0,
    reg_rxdata = 3'd1,
    reg_txctrl = 3'd2,
    reg_rxctrl = 3'd3,
    reg_ie     = 3'd4,
    reg_ip     = 3'd5,
    reg_div    = 3'd6
  } reg_addr_e;

  // Status flags in the data read words
  localparam int txdata_full_bit  = 31;
  localparam int rxdata_empty_bit = 31;

  // Control register fields
  localparam int txen_bit  = 0;
  localparam int nstop_bit = 1;
  localparam int rxen_bit  = 0;
  localparam int cnt_lsb   = 16;

  // ie and ip share one layout
  localparam int txwm_bit = 0;
  localparam int rxwm_bit = 1;

  localparam int div_width = 16;
  localparam int data_bits = 8;

  localparam int default_baud = 115200;

endpackage

// ==== logic/uart_ctrl_if.sv ====
`timescale 1ns/1ps

interface uart_ctrl_if import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 8
);

  localparam int cw = $clog2(FIFO_DEPTH);

  logic                 txen;
  logic                 rxen;
  logic                 nstop;
  logic [div_width-1:0] div;
  logic [cw-1:0]        txcnt;
  logic [cw-1:0]        rxcnt;
  logic [data_bits-1:0] tx_wr_data;

  logic                 tx_push;
  logic                 rx_pop;

  logic [data_bits-1:0] rx_rd_data;
  logic                 tx_full;
  logic                 rx_empty;
  logic                 tx_below_wm;
  logic                 rx_above_wm;

  modport bank (
    output txen, rxen, nstop, div, txcnt, rxcnt, tx_wr_data,
    input  rx_rd_data, tx_full, rx_empty, tx_below_wm, rx_above_wm
  );

  modport fsm (
    output tx_push, rx_pop
  );

  modport phy (
    input  txen, rxen, nstop, div, txcnt, rxcnt, tx_wr_data, tx_push, rx_pop,
    output rx_rd_data, tx_full, rx_empty, tx_below_wm, rx_above_wm
  );

endinterface

// ==== logic/uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          push,
  input  logic                          pop,
  input  logic [data_bits-1:0]          wr_data,
  output logic [data_bits-1:0]          rd_data,
  output logic [$clog2(FIFO_DEPTH):0]   count,
  output logic                          full,
  output logic                          empty
);

  localparam int aw = $clog2(FIFO_DEPTH);

  logic [data_bits-1:0] mem [FIFO_DEPTH];
  logic [aw-1:0]        wr_ptr;
  logic [aw-1:0]        rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  assign full    = (count == (aw + 1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head word is always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 enable,
  input  logic                 nstop,
  input  logic [div_width-1:0] div,
  input  logic                 data_valid,
  input  logic [data_bits-1:0] data,
  output logic                 data_taken,
  output logic                 txd
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

  localparam int bw = $clog2(data_bits);

  state_e               state;
  logic [div_width-1:0] baud_cnt;
  logic [bw-1:0]        bit_cnt;
  logic [data_bits-1:0] shift;
  logic                 bit_end;
  logic                 frame_end;

  assign bit_end   = (baud_cnt == div);
  assign frame_end = (state == st_stop) && bit_end && (!nstop || bit_cnt[0]);

  // A queued byte follows the last stop bit without an idle gap
  assign data_taken = enable && data_valid && ((state == st_idle) || frame_end);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else if (data_taken) begin
      state    <= st_start;
      baud_cnt <= '0;
      txd      <= 1'b0;
    end else begin
      if (state != st_idle) begin
        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      end
      if (bit_end) begin
        case (state)
          st_start: begin
            state   <= st_data;
            bit_cnt <= '0;
            txd     <= shift[0];
          end
          st_data: begin
            if (bit_cnt == bw'(data_bits - 1)) begin
              state   <= st_stop;
              bit_cnt <= '0;
              txd     <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              txd     <= shift[1];
            end
          end
          st_stop: begin
            if (frame_end) begin
              state <= st_idle;
            end else begin
              // second stop bit
              bit_cnt <= bw'(1);
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (data_taken) begin
      shift <= data;
    end else if (state == st_data && bit_end) begin
      shift <= shift >> 1;
    end
  end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 enable,
  input  logic [div_width-1:0] div,
  input  logic                 rxd,
  output logic                 data_valid,
  output logic [data_bits-1:0] data
);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

  localparam int bw = $clog2(data_bits);

  state_e               state;
  logic                 rxd_meta;
  logic                 rxd_sync;
  logic                 rxd_prev;
  logic [div_width-1:0] baud_cnt;
  logic [bw-1:0]        bit_cnt;
  logic                 start_edge;
  logic                 half_bit;
  logic                 full_bit;

  assign start_edge = rxd_prev && !rxd_sync;
  assign half_bit   = (baud_cnt == (div >> 1));
  assign full_bit   = (baud_cnt == div);

  // Line idles high
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state      <= st_idle;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= 1'b0;
      case (state)
        st_idle: begin
          baud_cnt <= '0;
          if (enable && start_edge) begin
            state <= st_start;
          end
        end
        st_start: begin
          if (half_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // Glitch on the line, not a real start bit
            state    <= rxd_sync ? st_idle : st_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        st_data: begin
          if (full_bit) begin
            baud_cnt <= '0;
            if (bit_cnt == bw'(data_bits - 1)) begin
              state <= st_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: begin
          if (full_bit) begin
            baud_cnt   <= '0;
            data_valid <= 1'b1;
            state      <= st_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clock) begin
    if (state == st_data && full_bit) begin
      data <= {rxd_sync, data[data_bits-1:1]};
    end
  end

endmodule

// ==== logic/uart_phy.sv ====
`timescale 1ns/1ps

module uart_phy import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic        clock,
  input  logic        rst_n,
  uart_ctrl_if.phy    ctrl,
  output logic        txd,
  input  logic        rxd
);

  localparam int cw = $clog2(FIFO_DEPTH);

  logic [data_bits-1:0] tx_head;
  logic [cw:0]          tx_count;
  logic                 tx_empty;
  logic                 tx_taken;
  logic [data_bits-1:0] rx_byte;
  logic                 rx_valid;
  logic [cw:0]          rx_count;

  uart_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) tx_fifo_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .push   (ctrl.tx_push),
    .pop    (tx_taken),
    .wr_data(ctrl.tx_wr_data),
    .rd_data(tx_head),
    .count  (tx_count),
    .full   (ctrl.tx_full),
    .empty  (tx_empty)
  );

  uart_tx tx_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .enable    (ctrl.txen),
    .nstop     (ctrl.nstop),
    .div       (ctrl.div),
    .data_valid(!tx_empty),
    .data      (tx_head),
    .data_taken(tx_taken),
    .txd       (txd)
  );

  uart_rx rx_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .enable    (ctrl.rxen),
    .div       (ctrl.div),
    .rxd       (rxd),
    .data_valid(rx_valid),
    .data      (rx_byte)
  );

  // Bytes arriving into a full FIFO are lost
  uart_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) rx_fifo_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .push   (rx_valid),
    .pop    (ctrl.rx_pop),
    .wr_data(rx_byte),
    .rd_data(ctrl.rx_rd_data),
    .count  (rx_count),
    .full   (),
    .empty  (ctrl.rx_empty)
  );

  assign ctrl.tx_below_wm = (tx_count < {1'b0, ctrl.txcnt});
  assign ctrl.rx_above_wm = (rx_count > {1'b0, ctrl.rxcnt});

endmodule

// ==== logic/uart_bank.sv ====
`timescale 1ns/1ps

module uart_bank import uart_pkg::*; #(
  parameter int FIFO_DEPTH    = 8,
  parameter int CLOCK_FREQ_HZ = 10000000
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        bank_rd,
  input  logic        bank_wr,
  input  reg_addr_e   addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rd_data,
  output logic        interrupt,
  uart_ctrl_if.bank   ctrl
);

  localparam int cw = $clog2(FIFO_DEPTH);
  localparam logic [div_width-1:0] div_reset = div_width'(CLOCK_FREQ_HZ / default_baud - 1);

  logic                 txen;
  logic                 nstop;
  logic [cw-1:0]        txcnt;
  logic                 rxen;
  logic [cw-1:0]        rxcnt;
  logic                 ie_txwm;
  logic                 ie_rxwm;
  logic [div_width-1:0] div;
  logic [31:0]          rd_word;

  assign ctrl.txen       = txen;
  assign ctrl.nstop      = nstop;
  assign ctrl.txcnt      = txcnt;
  assign ctrl.rxen       = rxen;
  assign ctrl.rxcnt      = rxcnt;
  assign ctrl.div        = div;
  assign ctrl.tx_wr_data = wr_data[data_bits-1:0];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      txen    <= 1'b0;
      nstop   <= 1'b0;
      txcnt   <= '0;
      rxen    <= 1'b0;
      rxcnt   <= '0;
      ie_txwm <= 1'b0;
      ie_rxwm <= 1'b0;
      div     <= div_reset;
    end else if (bank_wr) begin
      case (addr)
        reg_txctrl: begin
          txen  <= wr_data[txen_bit];
          nstop <= wr_data[nstop_bit];
          txcnt <= wr_data[cnt_lsb +: cw];
        end
        reg_rxctrl: begin
          rxen  <= wr_data[rxen_bit];
          rxcnt <= wr_data[cnt_lsb +: cw];
        end
        reg_ie: begin
          ie_txwm <= wr_data[txwm_bit];
          ie_rxwm <= wr_data[rxwm_bit];
        end
        reg_div: div <= wr_data[div_width-1:0];
        // txdata goes to the FIFO, ip and rxdata are read-only
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_word = '0;
    case (addr)
      reg_txdata: rd_word[txdata_full_bit] = ctrl.tx_full;
      reg_rxdata: begin
        rd_word[rxdata_empty_bit]  = ctrl.rx_empty;
        rd_word[data_bits-1:0]     = ctrl.rx_rd_data;
      end
      reg_txctrl: begin
        rd_word[txen_bit]          = txen;
        rd_word[nstop_bit]         = nstop;
        rd_word[cnt_lsb +: cw]     = txcnt;
      end
      reg_rxctrl: begin
        rd_word[rxen_bit]          = rxen;
        rd_word[cnt_lsb +: cw]     = rxcnt;
      end
      reg_ie: begin
        rd_word[txwm_bit]          = ie_txwm;
        rd_word[rxwm_bit]          = ie_rxwm;
      end
      reg_ip: begin
        rd_word[txwm_bit]          = ctrl.tx_below_wm;
        rd_word[rxwm_bit]          = ctrl.rx_above_wm;
      end
      reg_div: rd_word[div_width-1:0] = div;
      default: ;
    endcase
  end

  // Word is taken before the rxdata pop in the ack cycle
  always_ff @(posedge clock) begin
    if (bank_rd) begin
      rd_data <= rd_word;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      interrupt <= 1'b0;
    end else begin
      interrupt <= (ie_txwm && ctrl.tx_below_wm) || (ie_rxwm && ctrl.rx_above_wm);
    end
  end

endmodule

// ==== logic/uart_fsm.sv ====
`timescale 1ns/1ps

module uart_fsm import uart_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_w,
  output reg_addr_e   addr,
  output logic [31:0] wr_data,
  output logic        bank_rd,
  output logic        bank_wr,
  output logic        ack,
  uart_ctrl_if.fsm    ctrl
);

  typedef enum logic [1:0] {st_idle, st_access, st_ack} state_e;

  state_e state;
  logic   we_q;
  logic   request;

  assign request = cyc && stb && (state == st_idle);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:   state <= request ? st_access : st_idle;
        st_access: state <= st_ack;
        default:   state <= st_idle;
      endcase
    end
  end

  // Bus fields held for the whole access
  always_ff @(posedge clock) begin
    if (request) begin
      addr    <= reg_addr_e'(adr);
      wr_data <= dat_w;
      we_q    <= we;
    end
  end

  assign bank_rd = (state == st_access) && !we_q;
  assign bank_wr = (state == st_access) && we_q;
  assign ack     = (state == st_ack);

  // FIFO strobes line up with ack
  assign ctrl.tx_push = ack && we_q && (addr == reg_txdata);
  assign ctrl.rx_pop  = ack && !we_q && (addr == reg_rxdata);

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
  parameter int FIFO_DEPTH    = 8,
  parameter int CLOCK_FREQ_HZ = 10000000
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [2:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  input  logic        rxd,
  output logic        txd,
  output logic        interrupt
);

  reg_addr_e   addr;
  logic [31:0] wr_data;
  logic        bank_rd;
  logic        bank_wr;

  uart_ctrl_if #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) ctrl_i ();

  uart_fsm fsm_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .addr   (addr),
    .wr_data(wr_data),
    .bank_rd(bank_rd),
    .bank_wr(bank_wr),
    .ack    (ack),
    .ctrl   (ctrl_i.fsm)
  );

  uart_bank #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .CLOCK_FREQ_HZ(CLOCK_FREQ_HZ)
  ) bank_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .bank_rd  (bank_rd),
    .bank_wr  (bank_wr),
    .addr     (addr),
    .wr_data  (wr_data),
    .rd_data  (dat_r),
    .interrupt(interrupt),
    .ctrl     (ctrl_i.bank)
  );

  uart_phy #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) phy_i (
    .clock(clock),
    .rst_n(rst_n),
    .ctrl (ctrl_i.phy),
    .txd  (txd),
    .rxd  (rxd)
  );

endmodule

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;

  localparam int fifo_depth    = 8;
  localparam int clock_freq_hz = 10000000;
  localparam int baud_rate     = 115200;
  localparam int tx_div        = 7;
  localparam int bit_clocks    = tx_div + 1;
  localparam int frame_clocks  = 10 * bit_clocks;

  localparam logic [2:0] addr_txdata = 3'd0;
  localparam logic [2:0] addr_rxdata = 3'd1;
  localparam logic [2:0] addr_txctrl = 3'd2;
  localparam logic [2:0] addr_rxctrl = 3'd3;
  localparam logic [2:0] addr_ie     = 3'd4;
  localparam logic [2:0] addr_ip     = 3'd5;
  localparam logic [2:0] addr_div    = 3'd6;

  // Watermark count field sits at bit 16
  localparam logic [31:0] cnt_mask = 32'(fifo_depth - 1) << 16;

  logic        clock;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic        txd;
  logic        interrupt;
  integer      seed;

  // Serial loopback
  uart_top #(
    .FIFO_DEPTH   (fifo_depth),
    .CLOCK_FREQ_HZ(clock_freq_hz)
  ) uart_top_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .rxd      (txd),
    .txd      (txd),
    .interrupt(interrupt)
  );

  always #10 clock = ~clock;

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_on_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  ack_single_cycle: assert property (@(posedge clock) disable iff (!rst_n) ack |=> !ack)
    else stop_on_failure("ack stayed high for more than one cycle");

  ack_needs_stb: assert property (@(posedge clock) disable iff (!rst_n) ack |-> stb)
    else stop_on_failure("ack was high while stb was low");

  // Starts and ends on a falling edge, stb low for one edge afterwards
  task automatic wb_access(input logic write, input logic [2:0] a, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = a;
    dat_w = wdata;
    @(negedge clock);
    while (ack !== 1'b1) begin
      if (cycles >= 20) begin
        stop_on_failure("Wishbone access got no ack");
      end else begin
        @(negedge clock);
        cycles++;
      end
    end
    rdata = dat_r;
    @(negedge clock);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    @(negedge clock);
  endtask

  task automatic wb_write(input logic [2:0] a, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_access(1'b1, a, wdata, unused);
  endtask

  task automatic wb_read(input logic [2:0] a, output logic [31:0] rdata);
    wb_access(1'b0, a, 32'h0, rdata);
  endtask

  task automatic wait_txd_low();
    int cycles;
    cycles = 0;
    while (txd !== 1'b0) begin
      if (cycles >= 40) begin
        stop_on_failure("txd never fell for a start bit");
      end else begin
        @(negedge clock);
        cycles++;
      end
    end
  endtask

  task automatic wait_interrupt(input logic level);
    int cycles;
    cycles = 0;
    while (interrupt !== level) begin
      if (cycles >= 4 * frame_clocks) begin
        stop_on_failure($sformatf("interrupt did not reach level %0d", level));
      end else begin
        @(negedge clock);
        cycles++;
      end
    end
  endtask

  // Polls rxdata until a byte shows up
  task automatic read_rx_word(output logic [31:0] word);
    int tries;
    tries = 0;
    word = 32'h8000_0000;
    while (word[31] !== 1'b0) begin
      if (tries >= 300) begin
        stop_on_failure("no byte arrived in the receive FIFO");
      end else begin
        wb_read(addr_rxdata, word);
        tries++;
      end
    end
  endtask

  // Samples near mid-bit, half a clock after the falling edge is seen
  task automatic check_frame(input logic [7:0] b, input logic two_stop);
    int stop_clocks;
    stop_clocks = two_stop ? 2 * bit_clocks : bit_clocks;
    wait_txd_low();
    repeat (bit_clocks / 2 - 1) @(negedge clock);
    check_value("txd start bit", txd, 32'h0);
    for (int i = 0; i < 8; i++) begin
      repeat (bit_clocks) @(negedge clock);
      check_value($sformatf("txd data bit %0d", i), txd, b[i]);
    end
    repeat (bit_clocks / 2 + 1) @(negedge clock);
    for (int k = 0; k < stop_clocks; k++) begin
      check_value("txd stop bit", txd, 32'h1);
      @(negedge clock);
    end
  endtask

  // Second byte is queued mid-frame so its start bit bounds the stop level
  task automatic check_frame_pair(input logic two_stop);
    logic [31:0] first;
    logic [31:0] second;
    first = $random(seed);
    second = $random(seed);
    wb_write(addr_txdata, {24'h0, first[7:0]});
    fork
      check_frame(first[7:0], two_stop);
      begin
        repeat (bit_clocks) @(negedge clock);
        wb_write(addr_txdata, {24'h0, second[7:0]});
      end
    join
    check_value("txd start bit", txd, 32'h0);
    check_frame(second[7:0], two_stop);
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] value;
    logic [31:0] txctrl_word;
    logic [31:0] ip_before;
    logic [7:0]  tx_bytes [fifo_depth + 2];
    seed = 72512;
    clock = 1'b0;
    rst_n = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = 3'd0;
    dat_w = 32'h0;
    repeat (2) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);

    check_value("txd", txd, 32'h1);
    check_value("interrupt", interrupt, 32'h0);
    wb_read(addr_div, word);
    check_value("div", word, clock_freq_hz / baud_rate - 1);
    wb_read(addr_txctrl, word);
    check_value("txctrl", word, 32'h0);
    wb_read(addr_rxctrl, word);
    check_value("rxctrl", word, 32'h0);
    wb_read(addr_ie, word);
    check_value("ie", word, 32'h0);
    wb_read(addr_rxdata, word);
    check_value("rxdata[31]", word[31], 32'h1);

    // Register read back through the field masks
    value = $random(seed);
    wb_write(addr_div, value);
    wb_read(addr_div, word);
    check_value("div", word, value & 32'h0000_ffff);
    txctrl_word = $random(seed);
    wb_write(addr_txctrl, txctrl_word);
    wb_read(addr_txctrl, word);
    check_value("txctrl", word, txctrl_word & (cnt_mask | 32'h3));
    value = $random(seed);
    wb_write(addr_rxctrl, value);
    wb_read(addr_rxctrl, word);
    check_value("rxctrl", word, value & (cnt_mask | 32'h1));
    value = $random(seed);
    wb_write(addr_ie, value);
    wb_read(addr_ie, word);
    check_value("ie", word, value & 32'h3);
    wb_read(addr_ip, ip_before);
    check_value("ip", ip_before, {31'h0, (txctrl_word & cnt_mask) != 32'h0});
    value = $random(seed);
    wb_write(addr_ip, value);
    wb_read(addr_ip, word);
    check_value("ip", word, ip_before);
    wb_write(addr_ie, 32'h0);
    wb_write(addr_txctrl, 32'h0);
    wb_write(addr_rxctrl, 32'h0);
    wb_write(addr_div, tx_div);

    // Framing, one then two stop bits
    wb_write(addr_txctrl, 32'h1);
    check_frame_pair(1'b0);
    wb_write(addr_txctrl, 32'h3);
    check_frame_pair(1'b1);

    wb_write(addr_txctrl, 32'h1);
    wb_write(addr_rxctrl, 32'h1);
    for (int i = 0; i < 3; i++) begin
      value = $random(seed);
      tx_bytes[i] = value[7:0];
      wb_write(addr_txdata, {24'h0, tx_bytes[i]});
    end
    for (int i = 0; i < 3; i++) begin
      read_rx_word(word);
      check_value("rxdata", word, {24'h0, tx_bytes[i]});
    end
    wb_read(addr_rxdata, word);
    check_value("rxdata[31]", word[31], 32'h1);

    // Overfill the transmit FIFO while the transmitter is off
    wb_write(addr_txctrl, 32'h0);
    for (int i = 0; i < fifo_depth + 2; i++) begin
      value = $random(seed);
      tx_bytes[i] = value[7:0];
      wb_write(addr_txdata, {24'h0, tx_bytes[i]});
    end
    wb_read(addr_txdata, word);
    check_value("txdata", word, 32'h8000_0000);
    wb_write(addr_txctrl, 32'h1);
    for (int i = 0; i < fifo_depth; i++) begin
      read_rx_word(word);
      check_value("rxdata", word, {24'h0, tx_bytes[i]});
    end
    repeat (3 * frame_clocks) @(negedge clock);
    wb_read(addr_rxdata, word);
    check_value("rxdata[31]", word[31], 32'h1);

    // Watermark interrupts
    wb_write(addr_txctrl, 32'h0001_0000);
    value = $random(seed);
    wb_write(addr_txdata, {24'h0, value[7:0]});
    wb_write(addr_ie, 32'h1);
    check_value("interrupt", interrupt, 32'h0);
    wb_read(addr_ip, word);
    check_value("ip", word, 32'h0);
    wb_write(addr_txctrl, 32'h0001_0001);
    wait_interrupt(1'b1);
    wb_read(addr_ip, word);
    check_value("ip", word, 32'h1);
    wb_write(addr_ie, 32'h2);
    check_value("interrupt", interrupt, 32'h0);
    wait_interrupt(1'b1);
    wb_read(addr_ip, word);
    check_value("ip", word, 32'h3);
    wb_read(addr_rxdata, word);
    check_value("rxdata", word, {24'h0, value[7:0]});
    wait_interrupt(1'b0);
    wb_read(addr_ip, word);
    check_value("ip", word, 32'h1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
logic/uart_pkg.sv
logic/uart_ctrl_if.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_phy.sv
logic/uart_bank.sv
logic/uart_fsm.sv
logic/uart_top.sv
verif/uart_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = uart_tb
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
